// ==== Makefile ====
TOP = sbuf_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+common
common/sbuf_store_pkg.sv
common/sbuf_lookup_pkg.sv
sbuf/sbuf_queue.sv
sbuf/byte_merge_mux.sv
sbuf/store_buffer.sv
rtl/word_mem.sv
rtl/sbuf_top.sv
sim/sbuf_checker.sv
sim/sbuf_props.sv
sim/sbuf_tb.sv

// ==== common/sbuf_lookup_pkg.sv ====
// Forwarded data is only meaningful in the byte lanes whose mask bit is set.
`include "sbuf_params.svh"

package sbuf_lookup_pkg;

  // Bytes supplied by the store buffer for one load.
  typedef struct packed {
    logic [`SBUF_DATA_W-1:0] data;
    logic [`SBUF_MASK_W-1:0] mask;
  } fwd_result_t;

  // Array word read for a load, held for the response cycle.
  typedef struct packed {
    logic [`SBUF_DATA_W-1:0] data;
    logic [`SBUF_ADDR_W-1:0] addr;
  } load_resp_t;

endpackage

// ==== common/sbuf_params.svh ====
// Word width must be a whole number of bytes and the memory depth a power of two.
`ifndef SBUF_PARAMS_SVH
`define SBUF_PARAMS_SVH

// Byte address width.
`define SBUF_ADDR_W 12

// Word width in bits.
`define SBUF_DATA_W 32

// Words held by the memory array.
`define SBUF_MEM_WORDS 256

`define SBUF_MASK_W (`SBUF_DATA_W / 8)
`define SBUF_OFFSET_W $clog2(`SBUF_MASK_W)
`endif

// ==== common/sbuf_store_pkg.sv ====
// Store addresses are byte addresses, and a set store writes the whole word whatever its mask.
`include "sbuf_params.svh"

package sbuf_store_pkg;

  typedef logic [`SBUF_MASK_W-1:0] byte_mask_t;

  typedef logic [`SBUF_ADDR_W-`SBUF_OFFSET_W-1:0] word_addr_t;

  typedef struct packed {
    logic [`SBUF_ADDR_W-1:0] addr;
    logic [`SBUF_DATA_W-1:0] data;
    byte_mask_t              mask;
    logic                    set;  // Full-word store.
  } store_entry_t;

  function automatic word_addr_t word_addr(logic [`SBUF_ADDR_W-1:0] addr);
    return addr[`SBUF_ADDR_W-1:`SBUF_OFFSET_W];
  endfunction

  function automatic byte_mask_t eff_mask(store_entry_t entry);
    return entry.set ? '1 : entry.mask;  // Set overrides the byte mask.
  endfunction

endpackage

// ==== rtl/sbuf_top.sv ====
// Loads return after one cycle; stores retire after the post-reset clear and while not stalled.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_top
  import sbuf_store_pkg::*;
  import sbuf_lookup_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    store_v_i,
  input  store_entry_t            store_i,
  input  logic                    load_v_i,
  input  logic [`SBUF_ADDR_W-1:0] load_addr_i,
  input  logic                    drain_stall_i,
  output logic                    load_v_o,
  output logic [`SBUF_DATA_W-1:0] load_data_o,
  output logic                    sbuf_empty_o,
  output logic                    sbuf_full_o
);

  store_entry_t            drain;
  logic                    drain_v;
  logic                    drain_yumi;
  logic                    lookup_v;
  logic [`SBUF_ADDR_W-1:0] lookup_addr;
  fwd_result_t             fwd;

  store_buffer i_store_buffer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .store_v_i    (store_v_i),
    .store_i      (store_i),
    .drain_v_o    (drain_v),
    .drain_o      (drain),
    .drain_yumi_i (drain_yumi),
    .empty_o      (sbuf_empty_o),
    .full_o       (sbuf_full_o),
    .lookup_v_i   (lookup_v),
    .lookup_addr_i(lookup_addr),
    .fwd_o        (fwd)
  );

  word_mem i_word_mem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .drain_v_i    (drain_v),
    .drain_i      (drain),
    .drain_yumi_o (drain_yumi),
    .drain_stall_i(drain_stall_i),
    .load_v_i     (load_v_i),
    .load_addr_i  (load_addr_i),
    .lookup_v_o   (lookup_v),
    .lookup_addr_o(lookup_addr),
    .fwd_i        (fwd),
    .load_v_o     (load_v_o),
    .load_data_o  (load_data_o)
  );

endmodule

// ==== rtl/word_mem.sv ====
// Array clears itself after reset and holds drains until done; addresses alias modulo depth.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module word_mem
  import sbuf_store_pkg::*;
  import sbuf_lookup_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    drain_v_i,
  input  store_entry_t            drain_i,
  output logic                    drain_yumi_o,
  input  logic                    drain_stall_i,
  input  logic                    load_v_i,
  input  logic [`SBUF_ADDR_W-1:0] load_addr_i,
  output logic                    lookup_v_o,
  output logic [`SBUF_ADDR_W-1:0] lookup_addr_o,
  input  fwd_result_t             fwd_i,
  output logic                    load_v_o,
  output logic [`SBUF_DATA_W-1:0] load_data_o
);

  localparam int unsigned idx_w = $clog2(`SBUF_MEM_WORDS);

  logic [`SBUF_DATA_W-1:0] mem [`SBUF_MEM_WORDS];
  logic                    clearing_r;
  logic [idx_w-1:0]        clr_idx_r;
  word_addr_t              wr_word;
  word_addr_t              rd_word;
  logic [idx_w-1:0]        wr_idx;
  logic [idx_w-1:0]        rd_idx;
  byte_mask_t              wr_mask;
  load_resp_t              resp_n;
  load_resp_t              resp;
  logic                    load_v_r;

  assign drain_yumi_o = drain_v_i & ~drain_stall_i & ~clearing_r;
  assign wr_word = word_addr(drain_i.addr);
  assign wr_idx  = wr_word[idx_w-1:0];
  assign wr_mask = eff_mask(drain_i);
  assign rd_word = word_addr(load_addr_i);
  assign rd_idx  = rd_word[idx_w-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clearing_r <= 1'b1;
      clr_idx_r  <= '0;
    end else if (clearing_r) begin
      clr_idx_r  <= clr_idx_r + 1'b1;
      clearing_r <= (clr_idx_r != idx_w'(`SBUF_MEM_WORDS - 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (clearing_r) begin
      mem[clr_idx_r] <= '0;
    end else if (drain_yumi_o) begin
      for (int b = 0; b < `SBUF_MASK_W; b++) begin
        if (wr_mask[b]) begin
          mem[wr_idx][b*8 +: 8] <= drain_i.data[b*8 +: 8];
        end
      end
    end
  end

  // No drain lands during the sweep, so every word still reads as zero then.
  assign resp_n.data = clearing_r ? '0 : mem[rd_idx];
  assign resp_n.addr = load_addr_i;

  sbuf_queue #(
    .T(load_resp_t)
  ) i_resp_q (
    .clk_i      (clk_i),
    .data_i     (resp_n),
    .el0_en_i   (1'b0),
    .el1_en_i   (load_v_i),
    .mux0_sel_i (1'b0),
    .mux1_sel_i (1'b1),
    .el0_snoop_o(),
    .el1_snoop_o(),
    .data_o     (resp)
  );

  assign lookup_v_o    = load_v_i;
  assign lookup_addr_o = load_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_v_r <= 1'b0;
    end else begin
      load_v_r <= load_v_i;
    end
  end

  assign load_v_o = load_v_r;

  byte_merge_mux i_fwd_merge (
    .data0_i(resp.data),
    .data1_i(fwd_i.data),
    .sel_i  (fwd_i.mask),
    .data_o (load_data_o)
  );

endmodule

// ==== sbuf/byte_merge_mux.sv ====
// Selects per byte lane only; partial bytes are never merged.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module byte_merge_mux
  import sbuf_store_pkg::*;
(
  input  logic [`SBUF_DATA_W-1:0] data0_i,
  input  logic [`SBUF_DATA_W-1:0] data1_i,
  input  byte_mask_t              sel_i,
  output logic [`SBUF_DATA_W-1:0] data_o
);

  always_comb begin
    for (int b = 0; b < `SBUF_MASK_W; b++) begin
      if (sel_i[b]) begin
        data_o[b*8 +: 8] = data1_i[b*8 +: 8];
      end else begin
        data_o[b*8 +: 8] = data0_i[b*8 +: 8];
      end
    end
  end

endmodule

// ==== sbuf/sbuf_queue.sv ====
// Holds two elements without reset; the caller tracks occupancy and drives the enables.
`timescale 1ns/1ps

module sbuf_queue #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  T     data_i,
  input  logic el0_en_i,
  input  logic el1_en_i,
  input  logic mux0_sel_i,
  input  logic mux1_sel_i,
  output T     el0_snoop_o,
  output T     el1_snoop_o,
  output T     data_o
);

  T el0_r;
  T el1_r;
  T el1_next;

  // Head refills from the tail when one is held, else from the input.
  assign el1_next = mux0_sel_i ? el0_r : data_i;

  always_ff @(posedge clk_i) begin
    if (el0_en_i) begin
      el0_r <= data_i;
    end
    if (el1_en_i) begin
      el1_r <= el1_next;
    end
  end

  assign data_o = mux1_sel_i ? el1_r : data_i;  // Input passes through when empty.
  assign el0_snoop_o = el0_r;
  assign el1_snoop_o = el1_r;

endmodule

// ==== sbuf/store_buffer.sv ====
// No store ready: a store while full_o is high is only legal in a cycle where drain_yumi_i is high.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module store_buffer
  import sbuf_store_pkg::*;
  import sbuf_lookup_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    store_v_i,
  input  store_entry_t            store_i,
  output logic                    drain_v_o,
  output store_entry_t            drain_o,
  input  logic                    drain_yumi_i,
  output logic                    empty_o,
  output logic                    full_o,
  input  logic                    lookup_v_i,
  input  logic [`SBUF_ADDR_W-1:0] lookup_addr_i,
  output fwd_result_t             fwd_o
);

  logic [1:0]   num_els_r;
  logic         el0_valid;
  logic         el1_valid;
  logic         el0_en;
  logic         el1_en;
  logic         mux0_sel;
  logic         mux1_sel;
  store_entry_t el0_entry;
  store_entry_t el1_entry;

  always_comb begin
    drain_v_o = 1'b0;
    empty_o   = 1'b0;
    el0_valid = 1'b0;
    el1_valid = 1'b0;
    el0_en    = 1'b0;
    el1_en    = 1'b0;
    mux0_sel  = 1'b0;
    mux1_sel  = 1'b0;
    case (num_els_r)
      2'd0: begin
        drain_v_o = store_v_i;  // Empty buffer offers the incoming store directly.
        empty_o   = 1'b1;
        el1_en    = store_v_i & ~drain_yumi_i;
      end
      2'd1: begin
        drain_v_o = 1'b1;
        el1_valid = 1'b1;
        el0_en    = store_v_i & ~drain_yumi_i;
        el1_en    = store_v_i & drain_yumi_i;
        mux1_sel  = 1'b1;
      end
      2'd2: begin
        drain_v_o = 1'b1;
        el0_valid = 1'b1;
        el1_valid = 1'b1;
        el0_en    = store_v_i & drain_yumi_i;
        el1_en    = drain_yumi_i;  // Tail moves up to the head.
        mux0_sel  = 1'b1;
        mux1_sel  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign full_o = (num_els_r == 2'd2);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      num_els_r <= 2'd0;
    end else begin
      num_els_r <= num_els_r + 2'(store_v_i) - 2'(drain_v_o & drain_yumi_i);
    end
  end

  sbuf_queue #(
    .T(store_entry_t)
  ) i_entry_q (
    .clk_i      (clk_i),
    .data_i     (store_i),
    .el0_en_i   (el0_en),
    .el1_en_i   (el1_en),
    .mux0_sel_i (mux0_sel),
    .mux1_sel_i (mux1_sel),
    .el0_snoop_o(el0_entry),
    .el1_snoop_o(el1_entry),
    .data_o     (drain_o)
  );

  word_addr_t              lookup_word;
  logic                    hit0;
  logic                    hit1;
  logic                    hit2;
  byte_mask_t              sel0;
  byte_mask_t              sel1;
  byte_mask_t              sel2;
  logic [`SBUF_DATA_W-1:0] el_merge_data;
  fwd_result_t             fwd_n;

  // el0 is younger than el1, and the incoming store is youngest of all.
  assign lookup_word = word_addr(lookup_addr_i);
  assign hit0 = el0_valid & (word_addr(el0_entry.addr) == lookup_word);
  assign hit1 = el1_valid & (word_addr(el1_entry.addr) == lookup_word);
  assign hit2 = store_v_i & (word_addr(store_i.addr) == lookup_word);

  assign sel0 = hit0 ? eff_mask(el0_entry) : '0;
  assign sel1 = hit1 ? eff_mask(el1_entry) : '0;
  assign sel2 = hit2 ? eff_mask(store_i) : '0;

  byte_merge_mux i_merge_el (
    .data0_i(el1_entry.data),
    .data1_i(el0_entry.data),
    .sel_i  (sel0),
    .data_o (el_merge_data)
  );

  byte_merge_mux i_merge_in (
    .data0_i(el_merge_data),
    .data1_i(store_i.data),
    .sel_i  (sel2),
    .data_o (fwd_n.data)
  );

  assign fwd_n.mask = sel0 | sel1 | sel2;

  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      fwd_o <= fwd_n;  // Sampled with the array read in word_mem.
    end
  end

endmodule

// ==== sim/sbuf_checker.sv ====
// Model starts all zero and assumes addresses stay inside the memory, so no word aliases another.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_checker
  import sbuf_store_pkg::*;
#(
  parameter int NAME_W = 96
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [NAME_W-1:0]       name_i,
  input  logic                    store_v_i,
  input  store_entry_t            store_i,
  input  logic                    load_v_i,
  input  logic [`SBUF_ADDR_W-1:0] load_addr_i,
  input  logic                    resp_v_i,
  input  logic [`SBUF_DATA_W-1:0] resp_data_i,
  output int                      loads_o,
  output int                      errors_o
);

  localparam int MASK_W = `SBUF_DATA_W / 8;

  logic [7:0]              model [`SBUF_MEM_WORDS * MASK_W];
  logic [`SBUF_DATA_W-1:0] expected;
  logic [NAME_W-1:0]       pending_name;
  logic                    pending = 1'b0;
  int                      loads = 0;
  int                      errors = 0;

  initial begin
    for (int i = 0; i < `SBUF_MEM_WORDS * MASK_W; i++) begin
      model[i] = 8'h00;
    end
  end

  // Sampled on the falling edge, away from both the DUT registers and the stimulus.
  always @(negedge clk_i) begin
    int base;
    if (reset_i) begin
      pending = 1'b0;
    end else begin
      if (resp_v_i && !pending) begin
        $display("Load response appeared with no load issued, in test %0s", name_i);
        errors++;
      end else if (pending && !resp_v_i) begin
        $display("Load response missing one cycle after the load in test %0s", pending_name);
        errors++;
      end else if (pending) begin
        loads++;
        if (resp_data_i !== expected) begin
          $display("error %0s: expected %h, actual %h", pending_name, expected, resp_data_i);
          errors++;
        end
      end
      if (store_v_i) begin
        base = (int'(store_i.addr) / MASK_W % `SBUF_MEM_WORDS) * MASK_W;
        for (int b = 0; b < MASK_W; b++) begin
          if (store_i.set || store_i.mask[b]) begin
            model[base + b] = store_i.data[b*8 +: 8];  // Set writes every byte.
          end
        end
      end
      pending = load_v_i;  // Same-cycle store is already in the model.
      if (load_v_i) begin
        pending_name = name_i;
        base = (int'(load_addr_i) / MASK_W % `SBUF_MEM_WORDS) * MASK_W;
        for (int b = 0; b < MASK_W; b++) begin
          expected[b*8 +: 8] = model[base + b];
        end
      end
    end
  end

  assign loads_o  = loads;
  assign errors_o = errors;

endmodule

// ==== sim/sbuf_props.sv ====
// Reads the store buffer's occupancy counter directly; a store is only legal when full if yumi is high.
`timescale 1ns/1ps

module sbuf_props (
  input logic       clk_i,
  input logic       reset_i,
  input logic [1:0] num_els_i,
  input logic       store_v_i,
  input logic       drain_v_i,
  input logic       drain_yumi_i,
  input logic       empty_i,
  input logic       full_i
);

  int fail_count = 0;

  occupancy_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    num_els_i <= 2'd2)
  else begin
    fail_count++;
    $error("Store buffer occupancy went above two entries.");
  end

  drain_when_held: assert property (@(posedge clk_i) disable iff (reset_i)
    !empty_i |-> drain_v_i)
  else begin
    fail_count++;
    $error("Drain valid is low while the store buffer holds entries.");
  end

  no_store_when_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
    full_i && !drain_yumi_i |-> !store_v_i)
  else begin
    fail_count++;
    $error("A store arrived while the buffer was full and the drain was blocked.");
  end

endmodule

bind store_buffer sbuf_props i_sbuf_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .num_els_i   (num_els_r),
  .store_v_i   (store_v_i),
  .drain_v_i   (drain_v_o),
  .drain_yumi_i(drain_yumi_i),
  .empty_i     (empty_o),
  .full_i      (full_o)
);

// ==== sim/sbuf_tb.sv ====
// Directed rows keep addresses below 0x80 and random rows below 0x20, inside the memory.
`timescale 1ns/1ps
`include "sbuf_params.svh"

module sbuf_tb
  import sbuf_store_pkg::*;
();

  localparam int NAME_W      = 96;
  localparam int ADDR_W      = `SBUF_ADDR_W;
  localparam int DATA_W      = `SBUF_DATA_W;
  localparam int DRIVE_DELAY = 2;
  localparam int WAIT_LIMIT  = 600;
  localparam int RAND_ROWS   = 48;
  localparam logic [1:0] FULL_ANY = 2'd2;  // Occupancy is not predicted for random rows.

  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic              store_v;
    logic [ADDR_W-1:0] store_addr;
    byte_mask_t        store_mask;
    logic              store_set;
    logic              load_v;
    logic [ADDR_W-1:0] load_addr;
    logic              stall;
    logic              wait_empty;
    logic [1:0]        full_exp;  // Full level expected just after the row's edge.
  } row_t;

  logic              clk_i = 1'b0;
  logic              reset_i;
  logic              store_v_i;
  store_entry_t      store_i;
  logic              load_v_i;
  logic [ADDR_W-1:0] load_addr_i;
  logic              drain_stall_i;
  logic              load_v_o;
  logic [DATA_W-1:0] load_data_o;
  logic              sbuf_empty_o;
  logic              sbuf_full_o;
  logic [NAME_W-1:0] cur_name;
  logic [31:0]       rng_state = 32'hfdbb;
  row_t              table_q[$];
  logic              aborted = 1'b0;
  int                tb_errors = 0;
  int                chk_loads;
  int                chk_errors;
  int                total_errors;

  always #20 clk_i = ~clk_i;  // 40 ns period.

  sbuf_top i_sbuf_top (.*);

  sbuf_checker #(
    .NAME_W(NAME_W)
  ) i_sbuf_checker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .name_i     (cur_name),
    .store_v_i  (store_v_i),
    .store_i    (store_i),
    .load_v_i   (load_v_i),
    .load_addr_i(load_addr_i),
    .resp_v_i   (load_v_o),
    .resp_data_i(load_data_o),
    .loads_o    (chk_loads),
    .errors_o   (chk_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic add_row(input logic [NAME_W-1:0] name, input logic st_v,
                         input logic [ADDR_W-1:0] st_addr, input byte_mask_t st_mask,
                         input logic st_set, input logic ld_v, input logic [ADDR_W-1:0] ld_addr,
                         input logic stall, input logic wait_empty, input logic [1:0] full_exp);
    table_q.push_back('{name, st_v, st_addr, st_mask, st_set, ld_v, ld_addr,
                        stall, wait_empty, full_exp});
  endtask

  task automatic build_table();
    logic [31:0] r;
    add_row("st_full",    1'b1, 12'h010, 4'hf, 1'b0, 1'b0, 12'h000, 1'b0, 1'b1, 2'd0);
    add_row("st_part",    1'b1, 12'h010, 4'h5, 1'b0, 1'b0, 12'h000, 1'b0, 1'b1, 2'd0);
    add_row("ld_merge",   1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h012, 1'b0, 1'b0, 2'd0);
    add_row("ld_other",   1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h020, 1'b0, 1'b0, 2'd0);
    add_row("st_ld_same", 1'b1, 12'h030, 4'h3, 1'b0, 1'b1, 12'h031, 1'b0, 1'b0, 2'd0);
    add_row("ld_after",   1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h030, 1'b0, 1'b1, 2'd0);
    add_row("hold_st0",   1'b1, 12'h040, 4'h6, 1'b0, 1'b0, 12'h000, 1'b1, 1'b0, 2'd0);
    add_row("hold_st1",   1'b1, 12'h041, 4'h3, 1'b0, 1'b0, 12'h000, 1'b1, 1'b0, 2'd1);
    add_row("hold_ld",    1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h040, 1'b1, 1'b0, 2'd1);
    add_row("hold_other", 1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h010, 1'b1, 1'b1, 2'd1);
    add_row("reload",     1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h040, 1'b0, 1'b0, 2'd0);
    add_row("set_st0",    1'b1, 12'h050, 4'h1, 1'b0, 1'b0, 12'h000, 1'b1, 1'b0, 2'd0);
    add_row("set_st1",    1'b1, 12'h050, 4'h2, 1'b1, 1'b0, 12'h000, 1'b1, 1'b0, 2'd1);
    add_row("set_ld",     1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h050, 1'b1, 1'b1, 2'd1);
    add_row("set_reload", 1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h050, 1'b0, 1'b0, 2'd0);
    add_row("in_st0",     1'b1, 12'h060, 4'hc, 1'b0, 1'b0, 12'h000, 1'b1, 1'b0, 2'd0);
    add_row("in_st_ld",   1'b1, 12'h060, 4'h6, 1'b0, 1'b1, 12'h060, 1'b1, 1'b1, 2'd1);
    add_row("in_reload",  1'b0, 12'h000, 4'h0, 1'b0, 1'b1, 12'h060, 1'b0, 1'b0, 2'd0);
    for (int i = 0; i < RAND_ROWS; i++) begin
      r = next_rand();
      add_row("random", |r[1:0], ADDR_W'({r[4:2], r[6:5]}), r[10:7], r[13:11] == 3'd0,
              |r[15:14], ADDR_W'({r[18:16], r[20:19]}), r[21] & r[22], 1'b0, FULL_ANY);
    end
  endtask

  // Idles the inputs with the drain open until the buffer is empty or has a free entry.
  task automatic wait_buffer(input logic until_empty);
    int cycles;
    cycles = 0;
    store_v_i = 1'b0;
    load_v_i = 1'b0;
    drain_stall_i = 1'b0;
    while ((until_empty ? !sbuf_empty_o : sbuf_full_o) && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      cycles++;
    end
    if (until_empty ? !sbuf_empty_o : sbuf_full_o) begin
      $display("Timeout: store buffer did not drain in %0d cycles, test %0s", WAIT_LIMIT,
               cur_name);
      tb_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic apply_row(input row_t r);
    if (r.store_v && sbuf_full_o) begin
      wait_buffer(1'b0);
    end
    if (aborted) begin
      return;
    end
    cur_name = r.name;
    store_v_i = r.store_v;
    store_i.addr = r.store_addr;
    store_i.data = r.store_v ? next_rand() : '0;  // Stored data comes from the xorshift stream.
    store_i.mask = r.store_mask;
    store_i.set = r.store_set;
    load_v_i = r.load_v;
    load_addr_i = r.load_addr;
    drain_stall_i = r.stall;
    @(posedge clk_i);
    #DRIVE_DELAY;
    store_v_i = 1'b0;
    load_v_i = 1'b0;
    if (r.full_exp != FULL_ANY && sbuf_full_o !== r.full_exp[0]) begin
      $display("error %0s: expected full %0b, actual %0b", r.name, r.full_exp[0], sbuf_full_o);
      tb_errors++;
    end
    if (r.wait_empty) begin
      wait_buffer(1'b1);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    store_v_i = 1'b0;
    store_i = '0;
    load_v_i = 1'b0;
    load_addr_i = '0;
    drain_stall_i = 1'b0;
    cur_name = "reset";
    build_table();
    repeat (10) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    if (!sbuf_empty_o || load_v_o) begin
      $display("DUT is not idle after reset");
      tb_errors++;
    end
    for (int i = 0; i < table_q.size() && !aborted; i++) begin
      apply_row(table_q[i]);
    end
    if (!aborted) begin
      wait_buffer(1'b1);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    total_errors = chk_errors + tb_errors + i_sbuf_top.i_store_buffer.i_sbuf_props.fail_count;
    $display("Loads checked %0d, load errors %0d, tb errors %0d, assertion failures %0d",
             chk_loads, chk_errors, tb_errors, i_sbuf_top.i_store_buffer.i_sbuf_props.fail_count);
    if (total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
